// File: verilog/pattern_pkg.sv
// shared sizes and codes; BUF_DEPTH must be a power of two that fits PTR_W and CREDIT_W
`default_nettype none

package pattern_pkg;

	// ------------------------------------------------------------
	// data path widths
	// ------------------------------------------------------------
	// one pixel word
	localparam int PIX_W = 12;
	// geometry ports: pixels per line, lines, blanking
	localparam int GEOM_W = 12;
	// line checksum, wraps
	localparam int SUM_W = 20;

	// ------------------------------------------------------------
	// buffer and credits
	// ------------------------------------------------------------
	// entries, also the credit count after reset
	localparam int BUF_DEPTH = 16;
	// holds 0..BUF_DEPTH
	localparam int CREDIT_W = 5;
	// read and write pointers
	localparam int PTR_W = 4;

	// entry layout: marker bits sit above the pixel
	localparam int ENTRY_SOL = PIX_W;
	localparam int ENTRY_EOL = PIX_W + 1;
	localparam int ENTRY_EOF = PIX_W + 2;
	localparam int ENTRY_W = PIX_W + 3;

	// ------------------------------------------------------------
	// pattern modes
	// ------------------------------------------------------------
	localparam int MODE_W = 2;
	// index within the frame
	localparam logic [MODE_W-1:0] MODE_PIX_INC = 2'd0;
	// index since reset, runs across frames
	localparam logic [MODE_W-1:0] MODE_PIX_INC_NO_FVAL = 2'd1;
	// line index high, pixel in line low
	localparam logic [MODE_W-1:0] MODE_LINE_INC = 2'd2;
	// frames completed since reset
	localparam logic [MODE_W-1:0] MODE_FRAME_INC = 2'd3;

endpackage

`default_nettype wire

// File: verilog/video_timing.sv
// geometry must be nonzero and steady during a frame; a blanking of 0 still takes one cycle
`timescale 1ns/1ps
`default_nettype none

module video_timing (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              i_enable,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_active_pixels,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_active_lines,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_hblank,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_vblank,
	input  wire                              i_credit,
	output logic                             o_fval,
	output logic                             o_lval,
	output logic                             o_pix_stb
);

	typedef enum logic [1:0] {
		ST_VBLANK,
		ST_LINE,
		ST_HBLANK,
		ST_FEND
	} state_t;

	state_t                              state;
	logic  [pattern_pkg::GEOM_W-1:0]     pix_cnt;
	logic  [pattern_pkg::GEOM_W-1:0]     line_cnt;
	logic  [pattern_pkg::GEOM_W-1:0]     blank_cnt;
	logic  [pattern_pkg::CREDIT_W-1:0]   credits;
	logic                                last_pix;
	logic                                last_line;
	logic                                hblank_done;
	logic                                vblank_done;

	// ------------------------------------------------------------
	// position decode
	// ------------------------------------------------------------
	assign last_pix  = (pix_cnt == i_active_pixels - 1'b1);
	assign last_line = (line_cnt == i_active_lines - 1'b1);
	// zero blanking behaves as one cycle
	assign hblank_done = (i_hblank == '0) || (blank_cnt == i_hblank - 1'b1);
	assign vblank_done = (i_vblank == '0) || (blank_cnt == i_vblank - 1'b1);

	// strobe only with a credit in hand, else the line stretches
	assign o_pix_stb = (state == ST_LINE) && (credits != '0);
	assign o_lval    = (state == ST_LINE);
	// no hblank after the last line, fval drops right after its last pixel
	assign o_fval    = (state == ST_LINE) || (state == ST_HBLANK);

	// ------------------------------------------------------------
	// credit counter
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= pattern_pkg::CREDIT_W'(pattern_pkg::BUF_DEPTH);
		end else begin
			case ({o_pix_stb, i_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	// ------------------------------------------------------------
	// frame FSM
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= ST_VBLANK;
			pix_cnt   <= '0;
			line_cnt  <= '0;
			blank_cnt <= '0;
		end else begin
			case (state)
				ST_VBLANK: begin
					// count stops at the end of blanking and waits for enable
					if (vblank_done) begin
						if (i_enable) begin
							state    <= ST_LINE;
							pix_cnt  <= '0;
							line_cnt <= '0;
						end
					end else begin
						blank_cnt <= blank_cnt + 1'b1;
					end
				end
				ST_LINE: begin
					// pixel counter frozen while out of credits
					if (o_pix_stb) begin
						if (last_pix) begin
							pix_cnt   <= '0;
							blank_cnt <= '0;
							state     <= last_line ? ST_FEND : ST_HBLANK;
						end else begin
							pix_cnt <= pix_cnt + 1'b1;
						end
					end
				end
				ST_HBLANK: begin
					if (hblank_done) begin
						line_cnt <= line_cnt + 1'b1;
						state    <= ST_LINE;
					end else begin
						blank_cnt <= blank_cnt + 1'b1;
					end
				end
				default: begin
					// end of frame, one cycle then vertical blank
					line_cnt  <= '0;
					blank_cnt <= '0;
					state     <= ST_VBLANK;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/pattern_gen.sv
// expects lval and fval to fall right after the last strobe of a line and of a frame
`timescale 1ns/1ps
`default_nettype none

module pattern_gen (
	input  wire                             clk,
	input  wire                             reset,
	input  wire  [pattern_pkg::MODE_W-1:0]  i_mode,
	input  wire                             i_fval,
	input  wire                             i_lval,
	input  wire                             i_pix_stb,
	output logic                            o_wr,
	output logic [pattern_pkg::PIX_W-1:0]   o_data,
	output logic                            o_sol,
	output logic                            o_eol,
	output logic                            o_eof
);

	logic                                fval_reg;
	logic                                lval_reg;
	logic                                fval_rise;
	logic                                fval_fall;
	logic                                lval_rise;
	logic                                lval_fall;
	logic  [pattern_pkg::MODE_W-1:0]     mode_q;
	logic  [pattern_pkg::MODE_W-1:0]     mode_now;
	logic  [pattern_pkg::PIX_W-1:0]      frame_pix;
	logic  [pattern_pkg::PIX_W-1:0]      glob_pix;
	logic  [pattern_pkg::PIX_W-5:0]      line_idx;
	logic  [3:0]                         line_pix;
	logic  [pattern_pkg::PIX_W-1:0]      frame_cnt;
	logic  [pattern_pkg::PIX_W-1:0]      pix_value;
	logic                                first_pend;
	logic                                sol_q;

	// ------------------------------------------------------------
	// timing registers and edges
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			fval_reg <= 1'b0;
			lval_reg <= 1'b0;
		end else begin
			fval_reg <= i_fval;
			lval_reg <= i_lval;
		end
	end

	assign fval_rise = i_fval && !fval_reg;
	assign fval_fall = !i_fval && fval_reg;
	assign lval_rise = i_lval && !lval_reg;
	assign lval_fall = !i_lval && lval_reg;

	// first strobe may land on the fval rise itself
	assign mode_now = fval_rise ? i_mode : mode_q;

	// ------------------------------------------------------------
	// pattern counters
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			mode_q     <= pattern_pkg::MODE_PIX_INC;
			frame_pix  <= '0;
			glob_pix   <= '0;
			line_idx   <= '0;
			line_pix   <= '0;
			frame_cnt  <= '0;
			first_pend <= 1'b0;
		end else begin
			if (fval_rise) begin
				mode_q <= i_mode;
			end
			// index within the frame, cleared between frames
			if (!i_fval) begin
				frame_pix <= '0;
			end else if (i_pix_stb) begin
				frame_pix <= frame_pix + 1'b1;
			end
			// never cleared after reset
			if (i_pix_stb) begin
				glob_pix <= glob_pix + 1'b1;
			end
			// line index steps on each lval fall
			if (!i_fval) begin
				line_idx <= '0;
			end else if (lval_fall) begin
				line_idx <= line_idx + 1'b1;
			end
			// pixel in line, mod 16
			if (!i_lval) begin
				line_pix <= '0;
			end else if (i_pix_stb) begin
				line_pix <= line_pix + 1'b1;
			end
			if (fval_fall) begin
				frame_cnt <= frame_cnt + 1'b1;
			end
			// waiting for the first strobe of a stalled line
			if (i_pix_stb) begin
				first_pend <= 1'b0;
			end else if (lval_rise) begin
				first_pend <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------
	// value select and write stage
	// ------------------------------------------------------------
	always_comb begin
		case (mode_now)
			pattern_pkg::MODE_PIX_INC:         pix_value = frame_pix;
			pattern_pkg::MODE_PIX_INC_NO_FVAL: pix_value = glob_pix;
			pattern_pkg::MODE_LINE_INC:        pix_value = {line_idx, line_pix};
			default:                           pix_value = frame_cnt;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			o_wr <= 1'b0;
		end else begin
			o_wr <= i_pix_stb;
		end
	end

	// payload, qualified by o_wr
	always_ff @(posedge clk) begin
		o_data <= pix_value;
		sol_q  <= i_pix_stb && (lval_rise || first_pend);
	end

	// edges seen one cycle after the strobe line up with the write
	assign o_sol = o_wr && sol_q;
	assign o_eol = o_wr && lval_fall;
	assign o_eof = o_wr && fval_fall;

endmodule

`default_nettype wire

// File: verilog/credit_fifo.sv
// no full flag; the writer must hold a credit per write, pops while empty are dropped
`timescale 1ns/1ps
`default_nettype none

module credit_fifo (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              i_wr,
	input  wire  [pattern_pkg::ENTRY_W-1:0]  i_entry,
	input  wire                              i_pop,
	output logic [pattern_pkg::ENTRY_W-1:0]  o_entry,
	output logic                             o_empty,
	output logic                             o_credit
);

	logic  [pattern_pkg::ENTRY_W-1:0]    mem [pattern_pkg::BUF_DEPTH];
	logic  [pattern_pkg::PTR_W-1:0]      wr_ptr;
	logic  [pattern_pkg::PTR_W-1:0]      rd_ptr;
	logic  [pattern_pkg::PTR_W-1:0]      rd_next;
	logic  [pattern_pkg::CREDIT_W-1:0]   occupancy;
	logic                                pop_ok;

	assign o_empty = (occupancy == '0);
	assign pop_ok  = i_pop && !o_empty;
	// pointer the head follows after this cycle
	assign rd_next = rd_ptr + pattern_pkg::PTR_W'(pop_ok);

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (i_wr) begin
			mem[wr_ptr] <= i_entry;
		end
	end

	// registered head
	// bypass when the next head is being written this cycle
	always_ff @(posedge clk) begin
		if (i_wr && (wr_ptr == rd_next)) begin
			o_entry <= i_entry;
		end else begin
			o_entry <= mem[rd_next];
		end
	end

	// ------------------------------------------------------------
	// pointers, occupancy, credit return
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			occupancy <= '0;
			o_credit  <= 1'b0;
		end else begin
			if (i_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			rd_ptr <= rd_next;
			case ({i_wr, pop_ok})
				2'b10:   occupancy <= occupancy + 1'b1;
				2'b01:   occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
			// one credit per pop, next cycle
			o_credit <= pop_ok;
		end
	end

endmodule

`default_nettype wire

// File: verilog/pixel_sink.sv
// line sum is only meaningful when every line starts with a sol entry
`timescale 1ns/1ps
`default_nettype none

module pixel_sink (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              i_ready,
	input  wire  [pattern_pkg::ENTRY_W-1:0]  i_entry,
	input  wire                              i_empty,
	output logic                             o_pop,
	output logic                             o_pix_valid,
	output logic [pattern_pkg::PIX_W-1:0]    o_pix_data,
	output logic                             o_pix_sol,
	output logic                             o_pix_eol,
	output logic                             o_pix_eof,
	output logic [pattern_pkg::SUM_W-1:0]    o_line_sum,
	output logic                             o_line_sum_valid
);

	logic  [pattern_pkg::PIX_W-1:0]    head_pix;
	logic                              head_sol;
	logic                              head_eol;
	logic                              head_eof;
	logic  [pattern_pkg::SUM_W-1:0]    acc;
	logic  [pattern_pkg::SUM_W-1:0]    acc_next;

	// ------------------------------------------------------------
	// head entry fields
	// ------------------------------------------------------------
	assign head_pix = i_entry[pattern_pkg::PIX_W-1:0];
	assign head_sol = i_entry[pattern_pkg::ENTRY_SOL];
	assign head_eol = i_entry[pattern_pkg::ENTRY_EOL];
	assign head_eof = i_entry[pattern_pkg::ENTRY_EOF];

	// drain whenever the downstream side allows
	assign o_pop = i_ready && !i_empty;

	// sol restarts the sum with this pixel
	assign acc_next = head_sol ? pattern_pkg::SUM_W'(head_pix)
	                           : acc + pattern_pkg::SUM_W'(head_pix);

	// ------------------------------------------------------------
	// output stage
	// ------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			o_pix_valid      <= 1'b0;
			o_pix_sol        <= 1'b0;
			o_pix_eol        <= 1'b0;
			o_pix_eof        <= 1'b0;
			o_line_sum_valid <= 1'b0;
			acc              <= '0;
		end else begin
			o_pix_valid      <= o_pop;
			// markers low whenever no pixel goes out
			o_pix_sol        <= o_pop && head_sol;
			o_pix_eol        <= o_pop && head_eol;
			o_pix_eof        <= o_pop && head_eof;
			// same cycle as the eol pixel
			o_line_sum_valid <= o_pop && head_eol;
			if (o_pop) begin
				acc <= acc_next;
			end
		end
	end

	// payload, qualified by the valids
	always_ff @(posedge clk) begin
		if (o_pop) begin
			o_pix_data <= head_pix;
		end
		if (o_pop && head_eol) begin
			o_line_sum <= acc_next;
		end
	end

endmodule

`default_nettype wire

// File: verilog/pattern_subsys.sv
// strobe to output is 3 cycles with i_ready high and an empty buffer, longer under back-pressure
`timescale 1ns/1ps
`default_nettype none

module pattern_subsys (
	input  wire                              clk,
	input  wire                              reset,
	input  wire                              i_enable,
	input  wire  [pattern_pkg::MODE_W-1:0]   i_mode,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_active_pixels,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_active_lines,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_hblank,
	input  wire  [pattern_pkg::GEOM_W-1:0]   i_vblank,
	input  wire                              i_ready,
	output logic                             o_pix_valid,
	output logic [pattern_pkg::PIX_W-1:0]    o_pix_data,
	output logic                             o_pix_sol,
	output logic                             o_pix_eol,
	output logic                             o_pix_eof,
	output logic [pattern_pkg::SUM_W-1:0]    o_line_sum,
	output logic                             o_line_sum_valid
);

	// timing to pattern
	logic                              fval;
	logic                              lval;
	logic                              pix_stb;
	// pattern to buffer
	logic                              gen_wr;
	logic  [pattern_pkg::PIX_W-1:0]    gen_data;
	logic                              gen_sol;
	logic                              gen_eol;
	logic                              gen_eof;
	logic  [pattern_pkg::ENTRY_W-1:0]  wr_entry;
	// buffer to sink and back
	logic  [pattern_pkg::ENTRY_W-1:0]  head_entry;
	logic                              buf_empty;
	logic                              sink_pop;
	logic                              credit;

	// ------------------------------------------------------------
	// producer
	// ------------------------------------------------------------
	video_timing u_timing (
		.clk             (clk),
		.reset           (reset),
		.i_enable        (i_enable),
		.i_active_pixels (i_active_pixels),
		.i_active_lines  (i_active_lines),
		.i_hblank        (i_hblank),
		.i_vblank        (i_vblank),
		.i_credit        (credit),
		.o_fval          (fval),
		.o_lval          (lval),
		.o_pix_stb       (pix_stb)
	);

	pattern_gen u_pattern (
		.clk       (clk),
		.reset     (reset),
		.i_mode    (i_mode),
		.i_fval    (fval),
		.i_lval    (lval),
		.i_pix_stb (pix_stb),
		.o_wr      (gen_wr),
		.o_data    (gen_data),
		.o_sol     (gen_sol),
		.o_eol     (gen_eol),
		.o_eof     (gen_eof)
	);

	// pack pixel and markers into one buffer entry
	assign wr_entry[pattern_pkg::PIX_W-1:0]    = gen_data;
	assign wr_entry[pattern_pkg::ENTRY_SOL]    = gen_sol;
	assign wr_entry[pattern_pkg::ENTRY_EOL]    = gen_eol;
	assign wr_entry[pattern_pkg::ENTRY_EOF]    = gen_eof;

	// ------------------------------------------------------------
	// buffer and consumer
	// ------------------------------------------------------------
	credit_fifo u_fifo (
		.clk      (clk),
		.reset    (reset),
		.i_wr     (gen_wr),
		.i_entry  (wr_entry),
		.i_pop    (sink_pop),
		.o_entry  (head_entry),
		.o_empty  (buf_empty),
		.o_credit (credit)
	);

	pixel_sink u_sink (
		.clk              (clk),
		.reset            (reset),
		.i_ready          (i_ready),
		.i_entry          (head_entry),
		.i_empty          (buf_empty),
		.o_pop            (sink_pop),
		.o_pix_valid      (o_pix_valid),
		.o_pix_data       (o_pix_data),
		.o_pix_sol        (o_pix_sol),
		.o_pix_eol        (o_pix_eol),
		.o_pix_eof        (o_pix_eof),
		.o_line_sum       (o_line_sum),
		.o_line_sum_valid (o_line_sum_valid)
	);

endmodule

`default_nettype wire

// File: bench/tb_pattern_asserts.sv
// bound into every credit_fifo; occupancy is sampled from the buffer's internal counter
`timescale 1ns/1ps
`default_nettype none

module tb_pattern_asserts (
	input wire                              clk,
	input wire                              reset,
	input wire                              i_wr,
	input wire                              i_pop,
	input wire                              i_empty,
	input wire [pattern_pkg::CREDIT_W-1:0]  i_occupancy
);

	// failed checks so far
	int unsigned fail_count = 0;

	// ------------------------------------------------------------
	// buffer occupancy rules
	// ------------------------------------------------------------
	// credits should make a write into a full buffer impossible
	wr_not_full: assert property (@(posedge clk) disable iff (reset)
		i_wr |-> (i_occupancy < pattern_pkg::CREDIT_W'(pattern_pkg::BUF_DEPTH)))
		else begin
			$error("buffer written while full, occupancy %0d", i_occupancy);
			fail_count++;
		end

	// sink must gate its pop with the empty flag
	pop_not_empty: assert property (@(posedge clk) disable iff (reset)
		i_pop |-> !i_empty)
		else begin
			$error("buffer popped while empty");
			fail_count++;
		end

	// count can never pass the depth
	occ_in_range: assert property (@(posedge clk) disable iff (reset)
		i_occupancy <= pattern_pkg::CREDIT_W'(pattern_pkg::BUF_DEPTH))
		else begin
			$error("buffer occupancy %0d above depth", i_occupancy);
			fail_count++;
		end

endmodule

bind credit_fifo tb_pattern_asserts u_asserts (
	.clk         (clk),
	.reset       (reset),
	.i_wr        (i_wr),
	.i_pop       (i_pop),
	.i_empty     (o_empty),
	.i_occupancy (occupancy)
);

`default_nettype wire

// File: bench/tb_pattern_subsys.sv
// run from the project root; reads up to 32 hex cases from bench/pattern_cases.txt
`timescale 1ns/1ps
`default_nettype none

module tb_pattern_subsys;

	localparam int MAX_CASES  = 32;
	localparam int CASE_WORDS = 7;

	logic                              clk = 1'b0;
	logic                              reset;
	logic                              i_enable;
	logic [pattern_pkg::MODE_W-1:0]    i_mode;
	logic [pattern_pkg::GEOM_W-1:0]    i_active_pixels;
	logic [pattern_pkg::GEOM_W-1:0]    i_active_lines;
	logic [pattern_pkg::GEOM_W-1:0]    i_hblank;
	logic [pattern_pkg::GEOM_W-1:0]    i_vblank;
	logic                              i_ready;
	logic                              o_pix_valid;
	logic [pattern_pkg::PIX_W-1:0]     o_pix_data;
	logic                              o_pix_sol;
	logic                              o_pix_eol;
	logic                              o_pix_eof;
	logic [pattern_pkg::SUM_W-1:0]     o_line_sum;
	logic                              o_line_sum_valid;

	// case table with seven words per case and all ones in unused words
	logic [15:0]                       case_mem [0:MAX_CASES*CASE_WORDS-1];
	int                                num_cases;
	int                                ready_pct;
	int                                eof_seen;
	int                                mismatch_count;
	int                                other_errors;
	longint                            watchdog_ns;
	bit                                watchdog_armed = 1'b0;
	int unsigned                       rng_seed;
	int unsigned                       rng_junk;

	// expected pixels, their markers {eof, eol, sol} and one sum per line
	logic [pattern_pkg::PIX_W-1:0]     exp_pix_q [$];
	logic [2:0]                        exp_mark_q [$];
	logic [pattern_pkg::SUM_W-1:0]     exp_sum_q [$];

	// 4 ns clock
	always #2 clk = ~clk;

	pattern_subsys uut (
		.clk              (clk),
		.reset            (reset),
		.i_enable         (i_enable),
		.i_mode           (i_mode),
		.i_active_pixels  (i_active_pixels),
		.i_active_lines   (i_active_lines),
		.i_hblank         (i_hblank),
		.i_vblank         (i_vblank),
		.i_ready          (i_ready),
		.o_pix_valid      (o_pix_valid),
		.o_pix_data       (o_pix_data),
		.o_pix_sol        (o_pix_sol),
		.o_pix_eol        (o_pix_eol),
		.o_pix_eof        (o_pix_eof),
		.o_line_sum       (o_line_sum),
		.o_line_sum_valid (o_line_sum_valid)
	);

	// ------------------------------------------------------------
	// reference model
	// ------------------------------------------------------------
	// value of one pixel wrapped to the pixel width
	function automatic int pattern_value(input logic [pattern_pkg::MODE_W-1:0] mode,
	                                     input int frame, input int line, input int pix,
	                                     input int line_len, input int since_reset);
		int value;
		case (mode)
			pattern_pkg::MODE_PIX_INC:         value = line * line_len + pix;
			pattern_pkg::MODE_PIX_INC_NO_FVAL: value = since_reset;
			// 8 bit line index over 4 bit pixel in line
			pattern_pkg::MODE_LINE_INC:        value = (line % 256) * 16 + (pix % 16);
			default:                           value = frame;
		endcase
		return value % (1 << pattern_pkg::PIX_W);
	endfunction

	task automatic build_expected(input int mode, input int pixels, input int lines,
	                              input int frames);
		int f;
		int l;
		int p;
		int value;
		int since_reset;
		int line_sum;
		exp_pix_q.delete();
		exp_mark_q.delete();
		exp_sum_q.delete();
		// every case starts from reset, so the running count does too
		since_reset = 0;
		for (f = 0; f < frames; f++) begin
			for (l = 0; l < lines; l++) begin
				line_sum = 0;
				for (p = 0; p < pixels; p++) begin
					value = pattern_value(pattern_pkg::MODE_W'(mode), f, l, p, pixels,
					                      since_reset);
					since_reset++;
					line_sum = (line_sum + value) % (1 << pattern_pkg::SUM_W);
					exp_pix_q.push_back(pattern_pkg::PIX_W'(value));
					exp_mark_q.push_back({(p == pixels - 1) && (l == lines - 1),
					                      p == pixels - 1, p == 0});
				end
				exp_sum_q.push_back(pattern_pkg::SUM_W'(line_sum));
			end
		end
	endtask

	// ------------------------------------------------------------
	// checking
	// ------------------------------------------------------------
	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
	                           input string what);
		if (actual !== expected) begin
			mismatch_count++;
			$display("Fail at %0t: %s is %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	// one output cycle against the head of the expected stream
	task automatic observe_outputs();
		logic [2:0] mark;
		if (o_pix_valid) begin
			if (exp_pix_q.size() == 0) begin
				other_errors++;
				$display("a pixel came out after the expected stream was used up");
			end else begin
				mark = exp_mark_q.pop_front();
				check_value(o_pix_data, exp_pix_q.pop_front(), "o_pix_data");
				check_value(o_pix_sol, mark[0], "o_pix_sol");
				check_value(o_pix_eol, mark[1], "o_pix_eol");
				check_value(o_pix_eof, mark[2], "o_pix_eof");
				// sum comes with the eol pixel and only then
				check_value(o_line_sum_valid, mark[1], "o_line_sum_valid");
				if (mark[1]) begin
					check_value(o_line_sum, exp_sum_q.pop_front(), "o_line_sum");
				end
				if (mark[2]) begin
					eof_seen++;
				end
			end
		end else begin
			check_value(o_line_sum_valid, 1'b0, "o_line_sum_valid without pixel");
		end
	endtask

	// ------------------------------------------------------------
	// case control
	// ------------------------------------------------------------
	task automatic load_cases();
		int i;
		for (i = 0; i < MAX_CASES * CASE_WORDS; i++) begin
			case_mem[i] = 16'hffff;
		end
		$readmemh("bench/pattern_cases.txt", case_mem);
		num_cases = 0;
		while (num_cases < MAX_CASES && case_mem[num_cases * CASE_WORDS] !== 16'hffff) begin
			num_cases++;
		end
		if (num_cases == 0) begin
			other_errors++;
			$display("no test cases could be read from bench/pattern_cases.txt");
		end
	endtask

	// frames * (lines * (pixels + hblank) + vblank) per case, with a little per line
	// and per case overhead, scaled by the slowest ready duty plus 10 percent
	function automatic longint watchdog_limit();
		longint cycles;
		int c;
		int base;
		int lowest;
		cycles = 0;
		lowest = 100;
		for (c = 0; c < num_cases; c++) begin
			base = c * CASE_WORDS;
			cycles += longint'(case_mem[base+5]) * (longint'(case_mem[base+2])
			          * (case_mem[base+1] + case_mem[base+3] + 2) + case_mem[base+4] + 2) + 20;
			if (int'(case_mem[base+6]) < lowest) begin
				lowest = case_mem[base+6];
			end
		end
		if (lowest < 1) begin
			lowest = 1;
		end
		return cycles * 4 * 100 / lowest * 11 / 10;
	endfunction

	task automatic run_case(input int idx);
		int base;
		int frames;
		base      = idx * CASE_WORDS;
		frames    = case_mem[base+5];
		ready_pct = case_mem[base+6];
		build_expected(case_mem[base], case_mem[base+1], case_mem[base+2], frames);
		@(posedge clk);
		reset           <= 1'b1;
		i_enable        <= 1'b0;
		i_ready         <= 1'b0;
		i_mode          <= pattern_pkg::MODE_W'(case_mem[base]);
		i_active_pixels <= case_mem[base+1][pattern_pkg::GEOM_W-1:0];
		i_active_lines  <= case_mem[base+2][pattern_pkg::GEOM_W-1:0];
		i_hblank        <= case_mem[base+3][pattern_pkg::GEOM_W-1:0];
		i_vblank        <= case_mem[base+4][pattern_pkg::GEOM_W-1:0];
		repeat (10) @(posedge clk);
		reset    <= 1'b0;
		i_enable <= 1'b1;
		eof_seen = 0;
		// drive on the rising edge and look at the outputs half a cycle later
		while (eof_seen < frames) begin
			@(posedge clk);
			i_ready <= (($urandom % 100) < ready_pct);
			@(negedge clk);
			observe_outputs();
		end
		$display("case %0d done: mode %0d, %0d frames", idx, case_mem[base], frames);
	endtask

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial begin
		int c;
		int unsigned assert_fails;
		$timeformat(-9, 0, " ns", 0);
		rng_seed = 32'he8e44332;
		rng_junk = $urandom(rng_seed);
		mismatch_count = 0;
		other_errors   = 0;
		reset           <= 1'b1;
		i_enable        <= 1'b0;
		i_mode          <= pattern_pkg::MODE_PIX_INC;
		i_active_pixels <= '0;
		i_active_lines  <= '0;
		i_hblank        <= '0;
		i_vblank        <= '0;
		i_ready         <= 1'b0;
		load_cases();
		watchdog_ns    = watchdog_limit();
		watchdog_armed = 1'b1;
		for (c = 0; c < num_cases; c++) begin
			run_case(c);
		end
		assert_fails = uut.u_fifo.u_asserts.fail_count;
		$display("errors: %0d mismatches, %0d other, %0d assertions", mismatch_count,
		         other_errors, assert_fails);
		if (mismatch_count == 0 && other_errors == 0 && assert_fails == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// watchdog armed once the cases are known
	initial begin
		wait (watchdog_armed);
		#(watchdog_ns);
		$display("the run timed out after %0d ns without finishing all cases", watchdog_ns);
		$display("errors: %0d mismatches, %0d other, %0d assertions", mismatch_count,
		         other_errors + 1, uut.u_fifo.u_asserts.fail_count);
		$display("Result: FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
verilog/pattern_pkg.sv
verilog/video_timing.sv
verilog/pattern_gen.sv
verilog/credit_fifo.sv
verilog/pixel_sink.sv
verilog/pattern_subsys.sv
bench/tb_pattern_asserts.sv
bench/tb_pattern_subsys.sv

// File: Bender.yml
package:
  name: pattern_subsys

sources:
  # package first, then the leaf blocks, then the top level
  - files:
      - verilog/pattern_pkg.sv
      - verilog/video_timing.sv
      - verilog/pattern_gen.sv
      - verilog/credit_fifo.sv
      - verilog/pixel_sink.sv
      - verilog/pattern_subsys.sv

  # simulation only: bound checks and the testbench top
  - target: test
    files:
      - bench/tb_pattern_asserts.sv
      - bench/tb_pattern_subsys.sv

// File: bench/pattern_cases.txt
// one case per line, all fields hex: mode active_pixels active_lines hblank vblank frames ready_pct
// mode 0 pix_inc, 1 pix_inc across frames, 2 line_inc, 3 frame_inc; ready_pct 64=100 32=50 0a=10
0 010 004 004 008 2 64
0 00c 003 002 005 3 32
0 008 003 004 008 2 0a
1 010 004 004 008 3 64
1 00a 003 003 006 3 32
1 008 002 004 008 2 0a
2 014 005 004 008 2 64
2 024 003 002 004 2 32
2 008 003 004 008 2 0a
3 008 003 004 008 4 64
3 00c 002 002 005 3 32
3 008 002 004 008 3 0a
0 040 050 001 002 1 64
2 004 104 000 000 1 64
1 001 001 000 000 5 32
